// ==== Bender.yml ====
package:
  name: issue_core

sources:
  - files:
      - logic/isa_pkg.sv
      - logic/sched_pkg.sv
      - logic/sched_ifs.sv
      - logic/res_station.sv
      - logic/issue_select.sv
      - logic/exec_unit.sv
      - logic/sched_ctrl.sv
      - logic/issue_core.sv
  - target: test
    files:
      - test/tb_clock_gen.sv
      - test/issue_core_assertions.sv
      - test/tb_issue_core.sv

// ==== build.f ====
logic/isa_pkg.sv
logic/sched_pkg.sv
logic/sched_ifs.sv
logic/res_station.sv
logic/issue_select.sv
logic/exec_unit.sv
logic/sched_ctrl.sv
logic/issue_core.sv
test/tb_clock_gen.sv
test/issue_core_assertions.sv
test/tb_issue_core.sv

// ==== logic/exec_unit.sv ====
////////////////////////////////////////
// Execution unit
// Registers the issued operands, evaluates the
// op, broadcasts the result on the CDB
////////////////////////////////////////

module exec_unit (
    input  logic clock,
    input  logic rst,
    issue_if.ex  iss,
    input  logic res_done,   // Held product goes out now
    cdb_if.src   cdb
);
    import isa_pkg::*;
    import sched_pkg::*;

    word_t     ex_opa_q;
    word_t     ex_opb_q;
    alu_func_e ex_func_q;
    tag_t      ex_tag_q;     // Stable through the multiply
    logic      ex_vld_q;     // Op in the execute stage

    word_t     alu_res;
    logic      ex_is_mul;

    ////////////////////////////////////////
    // Operand stage
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (rst) begin
            ex_vld_q <= 1'b0;
        end else begin
            ex_vld_q <= iss.fire;
        end
    end

    always_ff @(posedge clock) begin
        if (iss.fire) begin
            ex_opa_q  <= iss.opa;
            ex_opb_q  <= iss.opb;
            ex_func_q <= iss.func;
            ex_tag_q  <= iss.tag;
        end
    end

    ////////////////////////////////////////
    // Datapath and result drive
    ////////////////////////////////////////

    assign alu_res   = alu_eval(ex_func_q, ex_opa_q, ex_opb_q);
    assign ex_is_mul = (lat_class(ex_func_q) == LAT_MULTI);

    // Single cycle ops go out right away while a multiply waits for control
    assign cdb.valid = (ex_vld_q && !ex_is_mul) || res_done;
    assign cdb.tag   = ex_tag_q;   // No fire while multiply is busy
    assign cdb.value = alu_res;    // Operands held through the multiply

endmodule

// ==== logic/isa_pkg.sv ====
////////////////////////////////////////
// ISA definitions for the integer issue back end
// Data word, ALU operation codes, latency class
// and the reference evaluation of each operation
////////////////////////////////////////

package isa_pkg;

    localparam int XLEN        = 32;
    localparam int SHAMT_W     = 5;   // Shift amount from low bits of opb
    localparam int MUL_LATENCY = 3;   // Issue to CDB for a multiply

    typedef logic [XLEN-1:0] word_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_MUL = 3'd7
    } alu_func_e;

    // Single cycle ops vs. the multi cycle multiply
    typedef enum logic {
        LAT_SINGLE,
        LAT_MULTI
    } lat_class_e;

    function automatic lat_class_e lat_class(alu_func_e f);
        return (f == ALU_MUL) ? LAT_MULTI : LAT_SINGLE;
    endfunction

    function automatic word_t alu_eval(alu_func_e f, word_t a, word_t b);
        logic [SHAMT_W-1:0] shamt;
        word_t              res;
        shamt = b[SHAMT_W-1:0];
        case (f)
            ALU_ADD: res = a + b;
            ALU_SUB: res = a - b;
            ALU_AND: res = a & b;
            ALU_OR:  res = a | b;
            ALU_XOR: res = a ^ b;
            ALU_SLL: res = a << shamt;
            ALU_SRL: res = a >> shamt;   // Logical, zero fill
            default: res = a * b;        // Low word of product
        endcase
        return res;
    endfunction

endpackage

// ==== logic/issue_core.sv ====
////////////////////////////////////////
// Issue back end top level
// Reservation station, select, control and
// execution unit around one CDB
////////////////////////////////////////

module issue_core (
    input  logic                clock,
    input  logic                rst,
    input  logic                dispatch_valid,
    input  isa_pkg::alu_func_e  dispatch_func,
    input  sched_pkg::tag_t     dispatch_tag,
    input  isa_pkg::word_t      src_a_value,
    input  sched_pkg::tag_t     src_a_tag,
    input  logic                src_a_wait,
    input  isa_pkg::word_t      src_b_value,
    input  sched_pkg::tag_t     src_b_tag,
    input  logic                src_b_wait,
    output logic                dispatch_ready,
    output logic                cdb_valid,
    output sched_pkg::tag_t     cdb_tag,
    output isa_pkg::word_t      cdb_value
);
    import isa_pkg::*;
    import sched_pkg::*;

    issue_if iss ();
    cdb_if   cdb ();

    logic               full;
    logic               fu_ready;
    logic               res_done;
    logic [RS_SIZE-1:0] ready_vec;
    word_t              ent_opa  [RS_SIZE];
    word_t              ent_opb  [RS_SIZE];
    alu_func_e          ent_func [RS_SIZE];
    tag_t               ent_tag  [RS_SIZE];

    res_station u_rs (
        .clock, .rst,
        .dispatch_valid, .dispatch_func, .dispatch_tag,
        .src_a_value, .src_a_tag, .src_a_wait,
        .src_b_value, .src_b_tag, .src_b_wait,
        .iss (iss), .cdb (cdb),
        .full, .ready_vec, .ent_opa, .ent_opb, .ent_func, .ent_tag
    );

    issue_select u_sel (
        .ready_vec, .ent_opa, .ent_opb, .ent_func, .ent_tag,
        .fu_ready, .iss (iss)
    );

    sched_ctrl u_ctrl (
        .clock, .rst, .full, .iss (iss),
        .dispatch_ready, .fu_ready, .res_done
    );

    exec_unit u_ex (
        .clock, .rst, .iss (iss), .res_done, .cdb (cdb)
    );

    // Result broadcast out to the renamer side
    assign cdb_valid = cdb.valid;
    assign cdb_tag   = cdb.tag;
    assign cdb_value = cdb.value;

endmodule

// ==== logic/issue_select.sv ====
////////////////////////////////////////
// Issue select
// Fixed priority pick of the lowest ready
// entry, forms the issue packet
////////////////////////////////////////

module issue_select (
    input  logic [sched_pkg::RS_SIZE-1:0] ready_vec,
    input  isa_pkg::word_t        ent_opa  [sched_pkg::RS_SIZE],
    input  isa_pkg::word_t        ent_opb  [sched_pkg::RS_SIZE],
    input  isa_pkg::alu_func_e    ent_func [sched_pkg::RS_SIZE],
    input  sched_pkg::tag_t       ent_tag  [sched_pkg::RS_SIZE],
    input  logic                  fu_ready,
    issue_if.sel                  iss
);
    import isa_pkg::*;
    import sched_pkg::*;

    logic picked;   // Stops the scan after first hit

    always_comb begin
        picked     = 1'b0;
        iss.fire   = 1'b0;
        iss.func   = ALU_ADD;   // Zero packet when nothing goes
        iss.opa    = '0;
        iss.opb    = '0;
        iss.tag    = '0;
        iss.rs_idx = '0;

        if (fu_ready) begin
            for (int i = 0; i < RS_SIZE; i++) begin
                if (!picked && ready_vec[i]) begin
                    iss.fire   = 1'b1;
                    iss.func   = ent_func[i];
                    iss.opa    = ent_opa[i];
                    iss.opb    = ent_opb[i];
                    iss.tag    = ent_tag[i];
                    iss.rs_idx = rs_idx_t'(i);   // Slot to free
                    picked     = 1'b1;
                end
            end
        end
    end

endmodule

// ==== logic/res_station.sv ====
////////////////////////////////////////
// Reservation station
// Holds dispatched ops until both operands
// are known, snoops the CDB for wakeup
////////////////////////////////////////

module res_station (
    input  logic                  clock,
    input  logic                  rst,
    input  logic                  dispatch_valid,
    input  isa_pkg::alu_func_e    dispatch_func,
    input  sched_pkg::tag_t       dispatch_tag,
    input  isa_pkg::word_t        src_a_value,
    input  sched_pkg::tag_t       src_a_tag,
    input  logic                  src_a_wait,
    input  isa_pkg::word_t        src_b_value,
    input  sched_pkg::tag_t       src_b_tag,
    input  logic                  src_b_wait,
    issue_if.ex                   iss,
    cdb_if.snoop                  cdb,
    output logic                  full,
    output logic [sched_pkg::RS_SIZE-1:0] ready_vec,
    output isa_pkg::word_t        ent_opa  [sched_pkg::RS_SIZE],
    output isa_pkg::word_t        ent_opb  [sched_pkg::RS_SIZE],
    output isa_pkg::alu_func_e    ent_func [sched_pkg::RS_SIZE],
    output sched_pkg::tag_t       ent_tag  [sched_pkg::RS_SIZE]
);
    import isa_pkg::*;
    import sched_pkg::*;

    logic [RS_SIZE-1:0] ent_vld;
    logic [RS_SIZE-1:0] a_wait;     // Operand A still pending
    logic [RS_SIZE-1:0] b_wait;
    tag_t               a_tag [RS_SIZE];
    tag_t               b_tag [RS_SIZE];

    rs_idx_t free_idx;
    logic    disp_acc;
    logic    byp_a, byp_b;          // Producer broadcasting this cycle

    ////////////////////////////////////////
    // Slot allocation
    ////////////////////////////////////////

    always_comb begin
        free_idx = '0;
        for (int i = RS_SIZE - 1; i >= 0; i--) begin
            if (!ent_vld[i]) free_idx = rs_idx_t'(i);   // Lowest free wins
        end
    end

    assign full      = &ent_vld;
    assign disp_acc  = dispatch_valid && !full;
    assign byp_a     = src_a_wait && cdb.valid && (cdb.tag == src_a_tag);
    assign byp_b     = src_b_wait && cdb.valid && (cdb.tag == src_b_tag);
    assign ready_vec = ent_vld & ~a_wait & ~b_wait;

    // Entry valid bits
    always_ff @(posedge clock) begin
        if (rst) begin
            ent_vld <= '0;
        end else begin
            if (iss.fire) ent_vld[iss.rs_idx] <= 1'b0;   // Free on issue
            if (disp_acc) ent_vld[free_idx]   <= 1'b1;   // Never the fired slot
        end
    end

    ////////////////////////////////////////
    // Entry payload, write and wakeup
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_SIZE; i++) begin
            if (disp_acc && (free_idx == rs_idx_t'(i))) begin
                ent_func[i] <= dispatch_func;
                ent_tag[i]  <= dispatch_tag;
                a_tag[i]    <= src_a_tag;
                b_tag[i]    <= src_b_tag;
                a_wait[i]   <= src_a_wait && !byp_a;
                b_wait[i]   <= src_b_wait && !byp_b;
                ent_opa[i]  <= byp_a ? cdb.value : src_a_value;
                ent_opb[i]  <= byp_b ? cdb.value : src_b_value;
            end else if (ent_vld[i]) begin
                // Grab the value on a CDB tag match
                if (a_wait[i] && cdb.valid && (a_tag[i] == cdb.tag)) begin
                    ent_opa[i] <= cdb.value;
                    a_wait[i]  <= 1'b0;
                end
                if (b_wait[i] && cdb.valid && (b_tag[i] == cdb.tag)) begin
                    ent_opb[i] <= cdb.value;
                    b_wait[i]  <= 1'b0;
                end
            end
        end
    end

endmodule

// ==== logic/sched_ctrl.sv ====
////////////////////////////////////////
// Scheduler control
// Tracks multiply occupancy of the unit and
// gives dispatch and issue back-pressure
////////////////////////////////////////

module sched_ctrl (
    input  logic clock,
    input  logic rst,
    input  logic full,
    issue_if.ctrl iss,
    output logic dispatch_ready,
    output logic fu_ready,
    output logic res_done
);
    import isa_pkg::*;
    import sched_pkg::*;

    ex_state_e state_q;
    mul_cnt_t  cnt_q;   // Cycles left until the product is due

    always_ff @(posedge clock) begin
        if (rst) begin
            state_q <= EX_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                EX_IDLE: begin
                    if (iss.fire && (lat_class(iss.func) == LAT_MULTI)) begin
                        state_q <= EX_MUL;
                        cnt_q   <= mul_cnt_t'(MUL_LATENCY - 1);
                    end
                end
                EX_MUL: begin
                    if (cnt_q == '0) begin
                        state_q <= EX_IDLE;   // Result slot this cycle
                    end else begin
                        cnt_q <= cnt_q - 1'b1;
                    end
                end
                default: state_q <= EX_IDLE;
            endcase
        end
    end

    // Unit is blocked through the result cycle so nothing collides
    assign fu_ready       = (state_q == EX_IDLE);
    assign res_done       = (state_q == EX_MUL) && (cnt_q == '0);
    assign dispatch_ready = !full;

endmodule

// ==== logic/sched_ifs.sv ====
////////////////////////////////////////
// Scheduler interfaces
// issue_if carries the issue packet from the
// select logic, cdb_if the result broadcast
////////////////////////////////////////

interface issue_if;
    import isa_pkg::*;
    import sched_pkg::*;

    logic      fire;     // One cycle issue pulse
    alu_func_e func;
    word_t     opa;
    word_t     opb;
    tag_t      tag;      // Destination tag
    rs_idx_t   rs_idx;   // Entry freed on fire

    modport sel (
        output fire, func, opa, opb, tag, rs_idx
    );

    modport ctrl (
        input fire, func
    );

    modport ex (
        input fire, func, opa, opb, tag, rs_idx
    );

endinterface

interface cdb_if;
    import isa_pkg::*;
    import sched_pkg::*;

    logic  valid;   // One pulse per result
    tag_t  tag;
    word_t value;

    modport src (
        output valid, tag, value
    );

    modport snoop (
        input valid, tag, value
    );

endinterface

// ==== logic/sched_pkg.sv ====
////////////////////////////////////////
// Scheduler definitions
// Reservation station size, tag and index
// types, execution control state
////////////////////////////////////////

package sched_pkg;

    localparam int RS_SIZE   = 8;                  // Reservation station entries
    localparam int IDX_W     = $clog2(RS_SIZE);
    localparam int TAG_W     = 4;                  // In-flight instruction tags
    localparam int MUL_CNT_W = 2;

    typedef logic [IDX_W-1:0]     rs_idx_t;
    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [MUL_CNT_W-1:0] mul_cnt_t;     // Multiply countdown

    // Execution unit occupancy
    typedef enum logic {
        EX_IDLE,    // Accepting work every cycle
        EX_MUL      // Multiply in flight, unit busy
    } ex_state_e;

endpackage

// ==== test/issue_cases.txt ====
# func  opnd_a    opnd_b    dest   (one instruction per line, hex)
# an operand is a value, or t plus the tag of its producer
add 00000005 00000003 1
sub 00000005 00000009 2
and f0f0ff00 0ff0f0f0 3
or  f0000001 00f00010 4
xor aaaa5555 ffff0000 5
sll 00000013 00000024 6
srl 80000000 0000003f 7
add t7 t6 8
xor 12345678 00000001 9
sub t8 0000000a a
mul t8 ta b
or  tb t9 c
srl tb 00000004 d
mul 00000007 00000006 1
mul t1 00000005 2
mul t2 t1 3
add t3 00000001 4
sub t3 00000100 5
and t3 0000ffff 6
or  t3 tc 7
xor t3 t1 e
sll t3 00000002 f
srl t3 00000001 0
mul t3 t3 8
add t4 t5 9

// ==== test/issue_core_assertions.sv ====
////////////////////////////////////////
// Issue back end protocol checks
// Bound into the top level, watches issue,
// result timing and dispatch back-pressure
////////////////////////////////////////

module issue_core_assertions (
    input logic               clock,
    input logic               rst,
    input logic               fire,
    input isa_pkg::alu_func_e func,
    input logic               fu_ready,
    input logic               dispatch_valid,
    input logic               dispatch_ready,
    input logic               cdb_valid
);
    import isa_pkg::*;
    import sched_pkg::*;

    int unsigned err_cnt = 0;   // Failed assertion count
    int          occupancy;     // Entries held, from accepted dispatch and issue

    always_ff @(posedge clock) begin
        if (rst) begin
            occupancy <= 0;
        end else begin
            occupancy <= occupancy + int'(dispatch_valid && dispatch_ready) - int'(fire);
        end
    end

    // Unit stays closed from the multiply issue through its result cycle
    a_mul_holds_unit: assert property (@(posedge clock) disable iff (rst)
        (fire && (func == ALU_MUL)) |=> (!fu_ready && !fire) [*MUL_LATENCY])
        else begin
            $error("issue or fu_ready seen while a multiply held the unit");
            err_cnt++;
        end

    a_alu_latency: assert property (@(posedge clock) disable iff (rst)
        (fire && (func != ALU_MUL)) |=> cdb_valid)
        else begin
            $error("single cycle op gave no result one cycle after issue");
            err_cnt++;
        end

    a_mul_latency: assert property (@(posedge clock) disable iff (rst)
        (fire && (func == ALU_MUL)) |-> ##MUL_LATENCY cdb_valid)
        else begin
            $error("multiply result not on the CDB after MUL_LATENCY cycles");
            err_cnt++;
        end

    a_full_blocks: assert property (@(posedge clock) disable iff (rst)
        (occupancy == RS_SIZE) |-> !dispatch_ready)
        else begin
            $error("dispatch_ready high with every entry valid");
            err_cnt++;
        end

endmodule

bind issue_core issue_core_assertions u_assert (
    .clock, .rst,
    .fire (iss.fire), .func (iss.func),
    .fu_ready, .dispatch_valid, .dispatch_ready, .cdb_valid
);

// ==== test/tb_clock_gen.sv ====
////////////////////////////////////////
// Testbench clock and reset
// 8 unit period, reset held for 3 cycles
////////////////////////////////////////

module tb_clock_gen (
    output logic clock,
    output logic rst
);
    localparam int HALF_PERIOD = 4;
    localparam int RST_CYCLES  = 3;
    localparam int REL_DLY     = 1;   // Same offset as the other inputs

    initial begin
        clock = 1'b0;
        forever #HALF_PERIOD clock = ~clock;
    end

    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clock);
        #REL_DLY rst = 1'b0;
    end

endmodule

// ==== test/tb_issue_core.sv ====
////////////////////////////////////////
// Testbench for the issue back end
// Acts as renamer from the case file, models
// results in program order, checks the CDB
////////////////////////////////////////

module tb_issue_core;
    import isa_pkg::*;
    import sched_pkg::*;

    localparam int    MAX_CASES = 64;
    localparam int    DRV_DLY   = 1;            // Input drive offset after the edge
    localparam int    NUM_TAGS  = 1 << TAG_W;
    localparam string CASE_FILE = "test/issue_cases.txt";

    logic      clock, rst;
    logic      dispatch_valid, dispatch_ready;
    alu_func_e dispatch_func;
    tag_t      dispatch_tag, src_a_tag, src_b_tag, cdb_tag;
    word_t     src_a_value, src_b_value, cdb_value;
    logic      src_a_wait, src_b_wait, cdb_valid;

    // Case table, operands resolved in program order
    alu_func_e c_func [MAX_CASES];
    tag_t      c_dst  [MAX_CASES];
    word_t     c_val  [MAX_CASES][2];
    logic      c_dep  [MAX_CASES][2];
    int        c_src  [MAX_CASES][2];   // Producing case of a tag operand
    word_t     c_exp  [MAX_CASES];
    logic      c_done [MAX_CASES];
    int        num_cases, results_seen;
    logic      loaded, any_dispatch, saw_stall;
    logic      tag_busy [NUM_TAGS];
    int        tag_case [NUM_TAGS];     // Case that owns an in-flight tag

    tb_clock_gen u_clk (.clock, .rst);
    issue_core   u_dut (.*);

    ////////////////////////////////////////
    // Reporting
    ////////////////////////////////////////

    task automatic stop_failed();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic report_error(input string msg);
        $display("error at %0t: %s", $time, msg);
        stop_failed();
    endtask

    task automatic check_equal(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s, got %h expected %h", $time, what, got, exp);
            stop_failed();
        end
    endtask

    ////////////////////////////////////////
    // Reference model and case loading
    ////////////////////////////////////////

    function automatic word_t model_op(alu_func_e f, word_t a, word_t b);
        case (f)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << b[4:0];   // Low 5 bits only
            ALU_SRL: return a >> b[4:0];
            default: return a * b;         // Low word of the product
        endcase
    endfunction

    function automatic alu_func_e func_of(string s);
        case (s)
            "add":   return ALU_ADD;
            "sub":   return ALU_SUB;
            "and":   return ALU_AND;
            "or":    return ALU_OR;
            "xor":   return ALU_XOR;
            "sll":   return ALU_SLL;
            "srl":   return ALU_SRL;
            default: return ALU_MUL;
        endcase
    endfunction

    task automatic parse_operand(input string tok, input int idx, input int k);
        string rest;
        tag_t  t;
        c_dep[idx][k] = (tok[0] == "t");
        c_src[idx][k] = -1;
        if (c_dep[idx][k]) begin
            rest = tok.substr(1, tok.len() - 1);
            t    = tag_t'(rest.atohex());
            for (int j = 0; j < idx; j++) begin
                if (c_dst[j] == t) c_src[idx][k] = j;   // Latest earlier writer
            end
            if (c_src[idx][k] < 0) report_error($sformatf("case %0d reads an unwritten tag", idx));
            c_val[idx][k] = c_exp[c_src[idx][k]];
        end else begin
            c_val[idx][k] = tok.atohex();
        end
    endtask

    task automatic load_cases();
        int               fd, got, dst;
        string            f_s, a_s, b_s;
        logic [8*128-1:0] line;
        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) report_error("cannot open the case file");
        while (!$feof(fd)) begin
            line = '0;
            got  = $fgets(line, fd);
            if (got != 0) got = $sscanf(line, "%s %s %s %h", f_s, a_s, b_s, dst);
            if (got == 4 && f_s[0] != "#") begin
                if (func_of(f_s) == ALU_MUL && f_s != "mul") report_error("unknown func name");
                c_func[num_cases] = func_of(f_s);
                c_dst[num_cases]  = tag_t'(dst);
                parse_operand(a_s, num_cases, 0);
                parse_operand(b_s, num_cases, 1);
                c_exp[num_cases]  = model_op(c_func[num_cases], c_val[num_cases][0],
                                             c_val[num_cases][1]);
                c_done[num_cases] = 1'b0;
                num_cases++;
            end
        end
        $fclose(fd);
        if (num_cases == 0) report_error("the case file holds no cases");
    endtask

    ////////////////////////////////////////
    // Renamer and dispatch
    ////////////////////////////////////////

    // Value once the producer has broadcast, tag and wait before that
    task automatic rename_operand(input int idx, input int k, output logic w,
                                  output tag_t t, output word_t v);
        w = c_dep[idx][k] && !c_done[c_src[idx][k]];
        t = w ? c_dst[c_src[idx][k]] : '0;
        v = w ? '0 : c_val[idx][k];
    endtask

    task automatic dispatch_case(input int idx);
        logic accepted;
        accepted = 1'b0;
        while (tag_busy[c_dst[idx]]) begin   // Tag reuse after its result only
            dispatch_valid = 1'b0;
            @(posedge clock);
            #DRV_DLY;
        end
        while (!accepted) begin
            dispatch_valid = 1'b1;
            dispatch_func  = c_func[idx];
            dispatch_tag   = c_dst[idx];
            rename_operand(idx, 0, src_a_wait, src_a_tag, src_a_value);
            rename_operand(idx, 1, src_b_wait, src_b_tag, src_b_value);
            accepted = dispatch_ready;         // Taken at the coming edge
            if (!accepted) saw_stall = 1'b1;
            @(posedge clock);
            #DRV_DLY;
        end
        tag_busy[c_dst[idx]] = 1'b1;
        tag_case[c_dst[idx]] = idx;
        any_dispatch         = 1'b1;
    endtask

    // CDB monitor, mid cycle where outputs are settled
    always @(negedge clock) begin
        int idx;
        if (!rst) begin
            if (u_dut.u_assert.err_cnt != 0) report_error("an assertion on the DUT failed");
            if (!any_dispatch) check_equal(cdb_valid, 1'b0, "cdb_valid before first dispatch");
            if (cdb_valid) begin
                if (!tag_busy[cdb_tag]) report_error("result for a tag that is not in flight");
                idx = tag_case[cdb_tag];
                check_equal(cdb_value, c_exp[idx], $sformatf("case %0d tag %h", idx, cdb_tag));
                c_done[idx]       = 1'b1;
                tag_busy[cdb_tag] = 1'b0;
                results_seen++;
            end
        end
    end

    initial begin
        dispatch_valid = 1'b0;
        dispatch_func  = ALU_ADD;
        dispatch_tag   = '0;
        src_a_value    = '0;
        src_a_tag      = '0;
        src_a_wait     = 1'b0;
        src_b_value    = '0;
        src_b_tag      = '0;
        src_b_wait     = 1'b0;
        num_cases      = 0;
        results_seen   = 0;
        loaded         = 1'b0;
        any_dispatch   = 1'b0;
        saw_stall      = 1'b0;
        foreach (tag_busy[i]) tag_busy[i] = 1'b0;
        load_cases();
        loaded = 1'b1;
        @(negedge rst);
        check_equal(dispatch_ready, 1'b1, "dispatch_ready after reset");
        repeat (4) begin   // Idle, the CDB has to stay quiet
            @(posedge clock);
            #DRV_DLY;
        end
        for (int i = 0; i < num_cases; i++) dispatch_case(i);
        dispatch_valid = 1'b0;
        wait (results_seen == num_cases);
        check_equal(saw_stall, 1'b1, "dispatch_ready never dropped");
        repeat (2) @(posedge clock);
        if (u_dut.u_assert.err_cnt == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_failed();
        end
    end

    // Watchdog, sized from the case count
    initial begin
        wait (loaded);
        repeat (num_cases * 10 + 50) @(posedge clock);
        report_error("timeout, not every result reached the CDB");
    end

endmodule
